// File: w5500_pkg.sv
// ****************************
// w5500 frame ids, spi stream types,
// register map and command codes
// ****************************
`default_nettype none

package w5500_pkg;

  // init frames first, then the send sequence in issue order
  typedef enum logic [3:0] {
    frm_gateway   = 4'd0,
    frm_mask      = 4'd1,
    frm_mac       = 4'd2,
    frm_local_ip  = 4'd3,
    frm_sock_mode = 4'd4,
    frm_src_port  = 4'd5,
    frm_sock_open = 4'd6,
    frm_dest_ip   = 4'd7,
    frm_dest_port = 4'd8,
    frm_rd_txwr   = 4'd9,
    frm_payload   = 4'd10,
    frm_wr_txwr   = 4'd11,
    frm_send      = 4'd12
  } frame_id_e;

  localparam frame_id_e INIT_FIRST = frm_gateway;
  localparam frame_id_e INIT_LAST  = frm_sock_open;

  // one byte on the spi stream, last closes the chip select frame
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } spi_beat_t;

  typedef struct packed {
    frame_id_e   id;
    logic [15:0] count;
  } frame_req_t;

  // common registers
  localparam logic [15:0] reg_gar      = 16'h0001;
  localparam logic [15:0] reg_subr     = 16'h0005;
  localparam logic [15:0] reg_shar     = 16'h0009;
  localparam logic [15:0] reg_sipr     = 16'h000f;

  // socket 0 registers
  localparam logic [15:0] reg_sn_mr    = 16'h0000;
  localparam logic [15:0] reg_sn_cr    = 16'h0001;
  localparam logic [15:0] reg_sn_port  = 16'h0004;
  localparam logic [15:0] reg_sn_dipr  = 16'h000c;
  localparam logic [15:0] reg_sn_dport = 16'h0010;
  localparam logic [15:0] reg_sn_tx_wr = 16'h0024;

  // control bytes, block select plus rw bit, variable length mode
  localparam logic [7:0] cmd_ctl_common_wr = 8'h04;
  localparam logic [7:0] cmd_ctl_sock_wr   = 8'h0c;
  localparam logic [7:0] cmd_ctl_sock_rd   = 8'h08;
  localparam logic [7:0] cmd_ctl_txbuf_wr  = 8'h14;

  localparam logic [7:0] cmd_mode_udp = 8'h02;
  localparam logic [7:0] cmd_open     = 8'h01;
  localparam logic [7:0] cmd_send     = 8'h20;

endpackage

`default_nettype wire

// File: udp_payload_fifo.sv
// ****************************
// single clock payload byte fifo
// ****************************
`timescale 1ns/1ps
`default_nettype none

module udp_payload_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic        clk,
  input  logic        rstn,
  input  logic [7:0]  in_data,
  input  logic        in_valid,
  output logic        in_ready,
  output logic [7:0]  rd_data,
  input  logic        rd_en,
  output logic [15:0] count
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [AW-1:0] LAST_PTR = AW'(FIFO_DEPTH - 1);
  localparam logic [15:0] DEPTH_W = 16'(FIFO_DEPTH);

  logic [7:0]    mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          wr_en;

  assign in_ready = (count != DEPTH_W);
  assign wr_en    = in_valid & in_ready;
  // head byte is always visible, rd_en pops it
  assign rd_data  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 16'd1;
        2'b01:   count <= count - 16'd1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: spi_byte_master.sv
// ****************************
// mode 0 spi byte shifter with
// per frame chip select
// ****************************
`timescale 1ns/1ps
`default_nettype none

module spi_byte_master #(
  parameter logic [7:0] SPI_DIV = 8'd4
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  w5500_pkg::spi_beat_t beat,
  input  logic                 beat_valid,
  output logic                 beat_ready,
  output logic [7:0]           rx_byte,
  output logic                 rx_valid,
  output logic                 sck,
  output logic                 mosi,
  input  logic                 miso,
  output logic                 cs_n
);

  typedef enum logic [1:0] {s_idle, s_shift, s_gap} sstate_e;

  sstate_e    state;
  logic [8:0] cnt;
  logic [2:0] bit_cnt;
  logic [7:0] tx_sh;
  logic [7:0] rx_sh;
  logic       last_q;
  logic       half_tick;
  logic       gap_end;

  assign half_tick  = (cnt == {1'b0, SPI_DIV} - 9'd1);
  assign gap_end    = (cnt == {SPI_DIV, 1'b0} - 9'd1);
  assign beat_ready = (state == s_idle);
  assign mosi       = tx_sh[7];
  assign rx_byte    = rx_sh;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state    <= s_idle;
      cnt      <= '0;
      bit_cnt  <= '0;
      tx_sh    <= '0;
      rx_sh    <= '0;
      last_q   <= 1'b0;
      sck      <= 1'b0;
      cs_n     <= 1'b1;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        s_idle: begin
          if (beat_valid) begin
            // msb goes out half a period ahead of the first rising edge
            tx_sh   <= beat.data;
            last_q  <= beat.last;
            cs_n    <= 1'b0;
            cnt     <= '0;
            bit_cnt <= '0;
            state   <= s_shift;
          end
        end
        s_shift: begin
          if (half_tick) begin
            cnt <= '0;
            sck <= ~sck;
            if (!sck) begin
              rx_sh <= {rx_sh[6:0], miso};
            end else begin
              // falling edge, next bit onto mosi
              bit_cnt <= bit_cnt + 3'd1;
              tx_sh   <= {tx_sh[6:0], 1'b0};
              if (bit_cnt == 3'd7) begin
                rx_valid <= 1'b1;
                if (last_q) begin
                  cs_n  <= 1'b1;
                  state <= s_gap;
                end else begin
                  state <= s_idle;
                end
              end
            end
          end else begin
            cnt <= cnt + 9'd1;
          end
        end
        s_gap: begin
          // chip select high time between frames
          if (gap_end) begin
            cnt   <= '0;
            state <= s_idle;
          end else begin
            cnt <= cnt + 9'd1;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: w5500_frame_builder.sv
// ****************************
// w5500 frame builder, header and
// data bytes onto the spi stream
// ****************************
`timescale 1ns/1ps
`default_nettype none

module w5500_frame_builder #(
  parameter logic [31:0] LOCAL_IP    = 32'hc0a8_01c7,
  parameter logic [31:0] GATEWAY_IP  = 32'hc0a8_0101,
  parameter logic [31:0] SUBNET_MASK = 32'hffff_ff00,
  parameter logic [47:0] MAC_ADDR    = 48'h0c29_ab7c_0001,
  parameter logic [15:0] SRC_PORT    = 16'h1388,
  parameter logic [31:0] DEST_IP     = 32'hc0a8_01be,
  parameter logic [15:0] DEST_PORT   = 16'h1770
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  w5500_pkg::frame_req_t frame_req,
  input  logic                  frame_valid,
  output logic                  frame_ready,
  output logic                  frame_done,
  output w5500_pkg::spi_beat_t  beat,
  output logic                  beat_valid,
  input  logic                  beat_ready,
  input  logic [7:0]            rx_byte,
  input  logic                  rx_valid,
  input  logic [7:0]            rd_data,
  output logic                  rd_en
);

  import w5500_pkg::*;

  typedef enum logic [1:0] {b_idle, b_send, b_wait} bstate_e;

  bstate_e     state;
  frame_req_t  req_q;
  logic [16:0] idx;
  logic [2:0]  rx_cnt;
  logic [15:0] tx_ptr;
  logic [15:0] ptr_next;
  logic [15:0] addr;
  logic [7:0]  ctl;
  logic [15:0] len;
  logic [47:0] data_word;
  logic [47:0] data_shift;
  logic [2:0]  d_idx;
  logic        last_beat;
  logic        payload_beat;

  assign ptr_next = tx_ptr + req_q.count;

  // address, control byte, data length and left aligned data per frame
  always_comb begin
    case (req_q.id)
      frm_gateway:   {addr, ctl, len, data_word} = {reg_gar, cmd_ctl_common_wr, 16'd4,
                                                    GATEWAY_IP, 16'h0};
      frm_mask:      {addr, ctl, len, data_word} = {reg_subr, cmd_ctl_common_wr, 16'd4,
                                                    SUBNET_MASK, 16'h0};
      frm_mac:       {addr, ctl, len, data_word} = {reg_shar, cmd_ctl_common_wr, 16'd6,
                                                    MAC_ADDR};
      frm_local_ip:  {addr, ctl, len, data_word} = {reg_sipr, cmd_ctl_common_wr, 16'd4,
                                                    LOCAL_IP, 16'h0};
      frm_sock_mode: {addr, ctl, len, data_word} = {reg_sn_mr, cmd_ctl_sock_wr, 16'd1,
                                                    cmd_mode_udp, 40'h0};
      frm_src_port:  {addr, ctl, len, data_word} = {reg_sn_port, cmd_ctl_sock_wr, 16'd2,
                                                    SRC_PORT, 32'h0};
      frm_sock_open: {addr, ctl, len, data_word} = {reg_sn_cr, cmd_ctl_sock_wr, 16'd1,
                                                    cmd_open, 40'h0};
      frm_dest_ip:   {addr, ctl, len, data_word} = {reg_sn_dipr, cmd_ctl_sock_wr, 16'd4,
                                                    DEST_IP, 16'h0};
      frm_dest_port: {addr, ctl, len, data_word} = {reg_sn_dport, cmd_ctl_sock_wr, 16'd2,
                                                    DEST_PORT, 32'h0};
      frm_rd_txwr:   {addr, ctl, len, data_word} = {reg_sn_tx_wr, cmd_ctl_sock_rd, 16'd2,
                                                    48'h0};
      // buffer offset is the pointer read back from the chip
      frm_payload:   {addr, ctl, len, data_word} = {tx_ptr, cmd_ctl_txbuf_wr, req_q.count,
                                                    48'h0};
      frm_wr_txwr:   {addr, ctl, len, data_word} = {reg_sn_tx_wr, cmd_ctl_sock_wr, 16'd2,
                                                    ptr_next, 32'h0};
      frm_send:      {addr, ctl, len, data_word} = {reg_sn_cr, cmd_ctl_sock_wr, 16'd1,
                                                    cmd_send, 40'h0};
      default:       {addr, ctl, len, data_word} = {16'h0, 8'h0, 16'd1, 48'h0};
    endcase
  end

  // data byte n of the frame sits at stream index n + 3
  assign d_idx      = idx[2:0] - 3'd3;
  assign data_shift = data_word << {d_idx, 3'b000};
  assign last_beat  = (idx == {1'b0, len} + 17'd2);

  always_comb begin
    case (idx)
      17'd0:   beat.data = addr[15:8];
      17'd1:   beat.data = addr[7:0];
      17'd2:   beat.data = ctl;
      default: beat.data = (req_q.id == frm_payload) ? rd_data : data_shift[47:40];
    endcase
    beat.last = last_beat;
  end

  assign frame_ready  = (state == b_idle);
  assign beat_valid   = (state == b_send);
  assign payload_beat = (req_q.id == frm_payload) && (idx > 17'd2);
  assign rd_en        = beat_valid & beat_ready & payload_beat;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state      <= b_idle;
      req_q      <= '{id: frm_gateway, count: 16'd0};
      idx        <= '0;
      rx_cnt     <= '0;
      tx_ptr     <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      if (rx_valid)
        rx_cnt <= rx_cnt + 3'd1;
      // pointer comes back msb first in the two data bytes
      if (rx_valid && req_q.id == frm_rd_txwr) begin
        if (rx_cnt == 3'd3)
          tx_ptr[15:8] <= rx_byte;
        if (rx_cnt == 3'd4)
          tx_ptr[7:0] <= rx_byte;
      end
      case (state)
        b_idle: begin
          if (frame_valid) begin
            req_q  <= frame_req;
            idx    <= '0;
            rx_cnt <= '0;
            state  <= b_send;
          end
        end
        b_send: begin
          if (beat_ready) begin
            idx <= idx + 17'd1;
            if (last_beat)
              state <= b_wait;
          end
        end
        b_wait: begin
          if (rx_valid) begin
            frame_done <= 1'b1;
            state      <= b_idle;
          end
        end
        default: state <= b_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: w5500_seq_ctrl.sv
// ****************************
// init table and send sequence FSM
// ****************************
`timescale 1ns/1ps
`default_nettype none

module w5500_seq_ctrl (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  send,
  input  logic [15:0]           fifo_count,
  output w5500_pkg::frame_req_t frame_req,
  output logic                  frame_valid,
  input  logic                  frame_ready,
  input  logic                  frame_done,
  output logic                  busy,
  output logic                  init_done
);

  import w5500_pkg::*;

  typedef enum logic [1:0] {st_idle, st_issue, st_wait_done, st_next} state_e;

  state_e      state;
  frame_id_e   cur_id;
  logic [15:0] burst_len;

  assign frame_valid = (state == st_issue);
  // every frame of a send carries the latched burst length
  assign frame_req   = '{id: cur_id, count: burst_len};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= st_idle;
      cur_id    <= INIT_FIRST;
      burst_len <= '0;
      busy      <= 1'b1;
      init_done <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (!init_done) begin
            state <= st_issue;
          end else if (send && fifo_count != 16'd0) begin
            // bytes written after this point wait for the next send
            burst_len <= fifo_count;
            cur_id    <= frm_dest_ip;
            busy      <= 1'b1;
            state     <= st_issue;
          end
        end

        st_issue: begin
          if (frame_ready)
            state <= st_wait_done;
        end

        st_wait_done: begin
          if (frame_done)
            state <= st_next;
        end

        st_next: begin
          if (cur_id == INIT_LAST) begin
            // socket open, ready for payload
            init_done <= 1'b1;
            busy      <= 1'b0;
            state     <= st_idle;
          end else if (cur_id == frm_send) begin
            busy  <= 1'b0;
            state <= st_idle;
          end else begin
            cur_id <= frame_id_e'(cur_id + 4'd1);
            state  <= st_issue;
          end
        end

        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: w5500_udp_top.sv
// ****************************
// w5500 udp sender top level
// ****************************
`timescale 1ns/1ps
`default_nettype none

module w5500_udp_top #(
  parameter logic [31:0] LOCAL_IP    = 32'hc0a8_01c7,
  parameter logic [31:0] GATEWAY_IP  = 32'hc0a8_0101,
  parameter logic [31:0] SUBNET_MASK = 32'hffff_ff00,
  parameter logic [47:0] MAC_ADDR    = 48'h0c29_ab7c_0001,
  parameter logic [15:0] SRC_PORT    = 16'h1388,
  parameter logic [31:0] DEST_IP     = 32'hc0a8_01be,
  parameter logic [15:0] DEST_PORT   = 16'h1770,
  parameter logic [7:0]  SPI_DIV     = 8'd4,
  parameter int          FIFO_DEPTH  = 16
) (
  input  logic       clk,
  input  logic       rstn,
  input  logic [7:0] in_data,
  input  logic       in_valid,
  output logic       in_ready,
  input  logic       send,
  output logic       busy,
  output logic       init_done,
  output logic       sck,
  output logic       mosi,
  input  logic       miso,
  output logic       cs_n
);

  import w5500_pkg::*;

  frame_req_t  frame_req;
  logic        frame_valid;
  logic        frame_ready;
  logic        frame_done;
  spi_beat_t   beat;
  logic        beat_valid;
  logic        beat_ready;
  logic [7:0]  rx_byte;
  logic        rx_valid;
  logic [7:0]  rd_data;
  logic        rd_en;
  logic [15:0] fifo_count;

  // port names match the nets below
  w5500_seq_ctrl u_ctrl (.*);

  w5500_frame_builder #(
    .LOCAL_IP    (LOCAL_IP),
    .GATEWAY_IP  (GATEWAY_IP),
    .SUBNET_MASK (SUBNET_MASK),
    .MAC_ADDR    (MAC_ADDR),
    .SRC_PORT    (SRC_PORT),
    .DEST_IP     (DEST_IP),
    .DEST_PORT   (DEST_PORT)
  ) u_builder (.*);

  udp_payload_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .count (fifo_count),
    .*
  );

  spi_byte_master #(
    .SPI_DIV (SPI_DIV)
  ) u_spi (.*);

endmodule

`default_nettype wire

// File: w5500_assert.sv
// ****************************
// spi master protocol assertions,
// bound into spi_byte_master
// ****************************
`timescale 1ns/1ps
`default_nettype none

module spi_protocol_checks (
  input logic                 clk,
  input logic                 rstn,
  input logic                 sck,
  input logic                 cs_n,
  input w5500_pkg::spi_beat_t beat,
  input logic                 beat_valid,
  input logic                 beat_ready,
  input logic                 rx_valid
);

  // sck rests low whenever the chip is deselected
  cs_idle: assert property (@(posedge clk) disable iff (!rstn) cs_n |-> !sck)
    else $error("sck high while cs_n is high");

  beat_hold: assert property (@(posedge clk) disable iff (!rstn)
    beat_valid && !beat_ready |=> beat_valid && $stable(beat))
    else $error("spi beat changed or dropped before it was taken");

  rx_pulse: assert property (@(posedge clk) disable iff (!rstn) rx_valid |=> !rx_valid)
    else $error("rx_valid longer than one cycle");

endmodule

bind spi_byte_master spi_protocol_checks u_spi_checks (
  .clk        (clk),
  .rstn       (rstn),
  .sck        (sck),
  .cs_n       (cs_n),
  .beat       (beat),
  .beat_valid (beat_valid),
  .beat_ready (beat_ready),
  .rx_valid   (rx_valid)
);

`default_nettype wire

// File: w5500_tb.sv
// ****************************
// directed testbench for the w5500 udp
// sender, with an spi slave model
// ****************************
`timescale 1ns/1ps
`default_nettype none

module w5500_tb;

  localparam logic [31:0] LOCAL_IP    = 32'hc0a8_01c7;
  localparam logic [31:0] GATEWAY_IP  = 32'hc0a8_0101;
  localparam logic [31:0] SUBNET_MASK = 32'hffff_ff00;
  localparam logic [47:0] MAC_ADDR    = 48'h0c29_ab7c_0001;
  localparam logic [15:0] SRC_PORT    = 16'h1388;
  localparam logic [31:0] DEST_IP     = 32'hc0a8_01be;
  localparam logic [15:0] DEST_PORT   = 16'h1770;
  localparam int          TIMEOUT     = 20000;

  logic       clk;
  logic       rstn;
  logic [7:0] in_data;
  logic       in_valid, in_ready, send, busy, init_done;
  logic       sck, mosi, miso, cs_n;

  // slave model state, bytes of all frames in one queue
  logic [7:0]  rx_bytes[$];
  int          frame_len[$];
  logic [7:0]  exp_q[$];
  logic [7:0]  pay_q[$];
  logic [7:0]  sh_in;
  logic [15:0] cur_addr;
  logic [7:0]  cur_ctl;
  logic [15:0] ptr_val;
  int          nbits, flen, errors, timeouts, checks, seed_init;

  w5500_udp_top #(
    .LOCAL_IP (LOCAL_IP), .GATEWAY_IP (GATEWAY_IP), .SUBNET_MASK (SUBNET_MASK),
    .MAC_ADDR (MAC_ADDR), .SRC_PORT (SRC_PORT), .DEST_IP (DEST_IP),
    .DEST_PORT (DEST_PORT), .SPI_DIV (8'd2), .FIFO_DEPTH (16)
  ) uut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(negedge cs_n) begin
    nbits    = 0;
    flen     = 0;
    cur_addr = '0;
    cur_ctl  = '0;
    miso    <= 1'b0;
  end

  always @(posedge sck) begin
    sh_in = {sh_in[6:0], mosi};
    nbits = nbits + 1;
    if (nbits % 8 == 0) begin
      rx_bytes.push_back(sh_in);
      flen = flen + 1;
      case (flen)
        1: cur_addr[15:8] = sh_in;
        2: cur_addr[7:0] = sh_in;
        3: cur_ctl = sh_in;
        default: ;
      endcase
    end
  end

  // answer a read of Sn_TX_WR with the pointer, msb first
  always @(negedge sck) begin
    if (cur_ctl == 8'h08 && cur_addr == 16'h0024 && nbits >= 24 && nbits < 40)
      miso <= ptr_val[39 - nbits];
    else
      miso <= 1'b0;
  end

  always @(posedge cs_n) begin
    if (flen > 0)
      frame_len.push_back(flen);
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("timeout at %0t ns: %s did not happen within %0d cycles", $time, what, TIMEOUT);
  endtask

  task automatic wait_init();
    int n = 0;
    while (!init_done && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!init_done)
      note_timeout("init_done");
  endtask

  task automatic wait_idle();
    int n = 0;
    while (busy && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (busy)
      note_timeout("busy falling");
  endtask

  // compare the oldest recorded frame with exp_q
  task automatic check_frame(input string name);
    int         n = 0;
    int         len;
    int         i;
    logic [7:0] b;
    while (frame_len.size() == 0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (frame_len.size() == 0) begin
      note_timeout({name, " frame"});
    end else begin
      len = frame_len.pop_front();
      check({name, " length"}, len, exp_q.size());
      for (i = 0; i < len; i++) begin
        b = rx_bytes.pop_front();
        if (i < exp_q.size())
          check($sformatf("%s byte %0d", name, i), b, exp_q[i]);
      end
    end
    exp_q.delete();
  endtask

  task automatic expect_hdr(input logic [15:0] addr, input logic [7:0] ctl);
    exp_q.push_back(addr[15:8]);
    exp_q.push_back(addr[7:0]);
    exp_q.push_back(ctl);
  endtask

  task automatic reg_frame(input string name, input logic [15:0] addr, input logic [7:0] ctl,
                           input logic [47:0] val, input int nbytes);
    int i;
    expect_hdr(addr, ctl);
    for (i = nbytes - 1; i >= 0; i--)
      exp_q.push_back(val[8*i +: 8]);
    check_frame(name);
  endtask

  task automatic put_byte(input logic [7:0] b);
    int n = 0;
    in_data  = b;
    in_valid = 1'b1;
    while (!in_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!in_ready)
      note_timeout("in_ready");
    else
      pay_q.push_back(b);
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic fill(input int n);
    int i;
    for (i = 0; i < n; i++)
      put_byte(8'($urandom));
  endtask

  task automatic pulse_send();
    @(negedge clk);
    send = 1'b1;
    @(negedge clk);
    send = 1'b0;
  endtask

  // six frames of one send, payload taken from the front of pay_q
  task automatic check_send(input int n);
    int i;
    reg_frame("dest ip", 16'h000c, 8'h0c, DEST_IP, 4);
    reg_frame("dest port", 16'h0010, 8'h0c, DEST_PORT, 2);
    reg_frame("tx_wr read", 16'h0024, 8'h08, 48'h0, 2);
    expect_hdr(ptr_val, 8'h14);
    for (i = 0; i < n; i++)
      exp_q.push_back(pay_q.pop_front());
    check_frame("payload");
    reg_frame("tx_wr write", 16'h0024, 8'h0c, 16'(ptr_val + n), 2);
    reg_frame("send cmd", 16'h0001, 8'h0c, 8'h20, 1);
    check("frames left after send", frame_len.size(), 0);
  endtask

  task automatic run_send(input int n);
    pulse_send();
    check("busy after send", busy, 1'b1);
    wait_idle();
    check_send(n);
  endtask

  task automatic init_test();
    check("busy before init", busy, 1'b1);
    check("init_done before init", init_done, 1'b0);
    wait_init();
    reg_frame("gateway", 16'h0001, 8'h04, GATEWAY_IP, 4);
    reg_frame("mask", 16'h0005, 8'h04, SUBNET_MASK, 4);
    reg_frame("mac", 16'h0009, 8'h04, MAC_ADDR, 6);
    reg_frame("local ip", 16'h000f, 8'h04, LOCAL_IP, 4);
    reg_frame("socket mode", 16'h0000, 8'h0c, 8'h02, 1);
    reg_frame("source port", 16'h0004, 8'h0c, SRC_PORT, 2);
    reg_frame("socket open", 16'h0001, 8'h0c, 8'h01, 1);
    check("frames left after init", frame_len.size(), 0);
    check("busy after init", busy, 1'b0);
  endtask

  task automatic empty_send_test();
    pulse_send();
    check("busy on empty send", busy, 1'b0);
    repeat (200) @(negedge clk);
    check("bytes on empty send", rx_bytes.size(), 0);
    check("busy after empty send", busy, 1'b0);
  endtask

  task automatic send_test(input int n);
    ptr_val = 16'($urandom);
    fill(n);
    run_send(n);
  endtask

  // full buffer, pointer chosen so the advanced value wraps
  task automatic full_test();
    ptr_val = 16'hfff8;
    fill(16);
    check("in_ready when full", in_ready, 1'b0);
    run_send(16);
    check("in_ready after send", in_ready, 1'b1);
  endtask

  task automatic overlap_test();
    int n1;
    int n2;
    n1      = $urandom_range(8, 1);
    n2      = $urandom_range(8, 1);
    ptr_val = 16'($urandom);
    fill(n1);
    pulse_send();
    check("busy after first send", busy, 1'b1);
    fill(n2);
    // request while busy is dropped
    pulse_send();
    check("busy after send while busy", busy, 1'b1);
    wait_idle();
    check_send(n1);
    // the dropped request starts no sequence of its own
    repeat (200) @(negedge clk);
    check("bytes after dropped send", rx_bytes.size(), 0);
    check("busy after dropped send", busy, 1'b0);
    ptr_val = 16'($urandom);
    run_send(n2);
  endtask

  initial begin
    seed_init = $urandom(61580);
    rstn      = 1'b0;
    in_data   = 8'h00;
    in_valid  = 1'b0;
    send      = 1'b0;
    miso      = 1'b0;
    nbits     = 0;
    flen      = 0;
    cur_addr  = '0;
    cur_ctl   = '0;
    ptr_val   = '0;
    errors    = 0;
    timeouts  = 0;
    checks    = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    check("cs_n after reset", cs_n, 1'b1);
    check("sck after reset", sck, 1'b0);
    init_test();
    empty_send_test();
    send_test($urandom_range(16, 1));
    full_test();
    overlap_test();
    $display("errors: %0d mismatches, %0d timeouts, %0d checks", errors, timeouts, checks);
    if (errors == 0 && timeouts == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
w5500_pkg.sv
udp_payload_fifo.sv
spi_byte_master.sv
w5500_frame_builder.sv
w5500_seq_ctrl.sv
w5500_udp_top.sv
w5500_assert.sv
w5500_tb.sv
